/* hdl/spiPkg.sv */
// shared constants for the SPI peripheral; register map is fixed at four 24-bit words
package spiPkg;

  // width of one register and of the data part of an SPI frame
  localparam int DataWidth = 24;

  // register map, selected by bits 1:0 of the command byte
  localparam logic [1:0] AddrCtrl = 2'd0;
  // blink period, in clk cycles minus one
  localparam logic [1:0] AddrPeriod = 2'd1;
  // free-running cycle timer, read only
  localparam logic [1:0] AddrTimer = 2'd2;
  localparam logic [1:0] AddrScratch = 2'd3;

  // command byte layout
  // bit 7 set means write, clear means read
  // bits 6:2 carry no meaning and are dropped
  localparam int CmdWriteBit = 7;

  // returned on miso while the master clocks in the command byte
  localparam logic [7:0] IdByte = 8'h5A;

  // control register fields
  // manual led drive
  localparam int CtrlLedBit = 0;
  // blink enable for the second led
  localparam int CtrlBlinkBit = 1;

  // command byte plus three data bytes
  // anything after this is ignored and answered with zeros
  localparam int FrameBytes = 4;

endpackage

/* hdl/spiEdgeSync.sv */
// assumes SPI mode 0 with sck half periods of at least 4 clk cycles; SyncStages must be 2 or more
`timescale 1ns/1ps

module spiEdgeSync #(
  parameter int SyncStages = 3
) (
  input  logic clk,
  input  logic rstN,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic sckRise,
  output logic sckFall,
  output logic frameStart,
  output logic frameEnd,
  output logic selActive,
  output logic mosiBit
);

  // one shift register per pin, newest sample in bit 0
  logic [SyncStages-1:0] sckSync;
  logic [SyncStages-1:0] sselSync;
  logic [SyncStages-1:0] mosiSync;

  // ssel resets high so no phantom frame edge is seen after reset
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      sckSync <= '0;
      sselSync <= '1;
      mosiSync <= '0;
    end
    else
    begin
      sckSync <= {sckSync[SyncStages-2:0], sck};
      sselSync <= {sselSync[SyncStages-2:0], ssel};
      mosiSync <= {mosiSync[SyncStages-2:0], mosi};
    end
  end

  // edges come from the two oldest stages
  // older 0 and newer 1 is a rising edge
  assign sckRise = !sckSync[SyncStages-1] && sckSync[SyncStages-2];
  assign sckFall = sckSync[SyncStages-1] && !sckSync[SyncStages-2];

  // select is active low, so a frame opens on its falling edge
  assign frameStart = sselSync[SyncStages-1] && !sselSync[SyncStages-2];
  assign frameEnd = !sselSync[SyncStages-1] && sselSync[SyncStages-2];
  assign selActive = !sselSync[SyncStages-2];

  // mosi taken at the same age as the newer sck stage
  // so it lines up with the sckRise strobe
  assign mosiBit = mosiSync[SyncStages-2];

endmodule

/* hdl/spiShiftUnit.sv */
// byte-level SPI shifter, MSB first, mode 0; expects txLoad between the 8th rise and the next fall
`timescale 1ns/1ps

module spiShiftUnit (
  input  logic       clk,
  input  logic       rstN,
  input  logic       sckRise,
  input  logic       sckFall,
  input  logic       selActive,
  input  logic       mosiBit,
  input  logic       txLoad,
  input  logic [7:0] txByte,
  output logic [7:0] rxByte,
  output logic       byteDone,
  output logic       miso
);

  // bit position inside the current byte
  logic [2:0] bitCnt;
  // receive shifter, filled from the LSB end
  logic [7:0] rxShift;
  // transmit shifter, MSB drives miso
  logic [7:0] txShift;
  // high on the rise that carries the 8th bit
  logic lastBit;

  assign lastBit = selActive && sckRise && (bitCnt == 3'd7);

  // bit counter only runs inside a frame
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      bitCnt <= 3'd0;
      byteDone <= 1'b0;
    end
    else
    begin
      // strobe one cycle after the last rise of the byte
      byteDone <= lastBit;
      if (!selActive)
        bitCnt <= 3'd0;
      else if (sckRise)
        bitCnt <= bitCnt + 3'd1;
    end
  end

  // receive data path
  always_ff @(posedge clk)
  begin
    if (selActive && sckRise)
      rxShift <= {rxShift[6:0], mosiBit};
    // full byte held until the next byte is complete
    if (lastBit)
      rxByte <= {rxShift[6:0], mosiBit};
  end

  // transmit shifter
  // the fall right after the 8th rise finds bitCnt back at 0
  // and must not shift, since the next byte was just loaded
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      txShift <= 8'h00;
    else if (txLoad)
      txShift <= txByte;
    else if (!selActive)
      txShift <= 8'h00;
    else if (sckFall && (bitCnt != 3'd0))
      txShift <= {txShift[6:0], 1'b0};
  end

  // single slave on the bus, so miso is never tri-stated
  assign miso = txShift[7];

  // a byte needs eight sck rises, each several clk cycles apart
  byteDoneSingle: assert property (
    @(posedge clk) disable iff (!rstN) byteDone |=> !byteDone
  );

endmodule

/* hdl/spiFrameCtrl.sv */
// frame sequencer for command byte plus three data bytes; writes commit only on a complete frame
`timescale 1ns/1ps

module spiFrameCtrl (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         frameStart,
  input  logic                         frameEnd,
  input  logic                         byteDone,
  input  logic [7:0]                   rxByte,
  input  logic [spiPkg::DataWidth-1:0] regRdata,
  output logic                         txLoad,
  output logic                         regWrite,
  output logic [7:0]                   txByte,
  output logic [1:0]                   regAddr,
  output logic [spiPkg::DataWidth-1:0] regWdata
);

  localparam int DataBytes = spiPkg::FrameBytes - 1;
  localparam int Dw = spiPkg::DataWidth;

  typedef enum logic [1:0] {StIdle, StCmd, StData, StOver} ctrlStateT;

  ctrlStateT state;
  // data bytes seen so far in this frame
  logic [1:0] byteCnt;
  // command fields latched at the end of the command byte
  logic writeQ;
  logic [1:0] addrQ;
  // read word, shifted up one byte per data byte
  logic [Dw-1:0] rdWord;
  logic cmdDone;
  logic cmdIsWrite;
  logic lastData;

  assign cmdDone = byteDone && (state == StCmd);
  assign cmdIsWrite = rxByte[spiPkg::CmdWriteBit];
  assign lastData = byteDone && (state == StData) && (byteCnt == 2'(DataBytes - 1));

  // address comes straight from the command byte while it completes
  // so the read word is captured in that same cycle
  assign regAddr = cmdDone ? rxByte[1:0] : addrQ;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= StIdle;
      byteCnt <= 2'd0;
      writeQ <= 1'b0;
      addrQ <= 2'd0;
      txLoad <= 1'b0;
      regWrite <= 1'b0;
    end
    else
    begin
      // both strobes last one cycle
      txLoad <= 1'b0;
      regWrite <= 1'b0;
      if (frameEnd)
      begin
        // ssel went high, any partial write is dropped here
        state <= StIdle;
        byteCnt <= 2'd0;
      end
      else if (frameStart)
      begin
        state <= StCmd;
        byteCnt <= 2'd0;
        txLoad <= 1'b1;
      end
      else if (byteDone)
      begin
        case (state)
          StCmd:
          begin
            writeQ <= cmdIsWrite;
            addrQ <= rxByte[1:0];
            state <= StData;
            txLoad <= 1'b1;
          end
          StData:
          begin
            byteCnt <= byteCnt + 2'd1;
            txLoad <= 1'b1;
            if (lastData)
            begin
              state <= StOver;
              // commit all three bytes together
              regWrite <= writeQ;
            end
          end
          // extra bytes just get zeros back
          StOver: txLoad <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // payload path, qualified by the control strobes above
  always_ff @(posedge clk)
  begin
    if (frameStart)
      txByte <= spiPkg::IdByte;
    else if (cmdDone)
    begin
      // timer is snapshotted here for a read
      rdWord <= cmdIsWrite ? '0 : regRdata;
      txByte <= cmdIsWrite ? 8'h00 : regRdata[Dw-1 -: 8];
    end
    else if (byteDone && (state == StData || state == StOver))
    begin
      // rdWord drains to zero after the last data byte
      txByte <= rdWord[Dw-9 -: 8];
      rdWord <= rdWord << 8;
    end
    // write data assembled MSB byte first
    if (byteDone && (state == StData))
      regWdata <= {regWdata[Dw-9:0], rxByte};
  end

  // write commit must land while select is still low
  writeInsideFrame: assert property (
    @(posedge clk) disable iff (!rstN)
    regWrite |-> !frameEnd
  );

endmodule

/* hdl/regBank.sv */
// four-word register map; timer address is read only and TimerWidth must not exceed DataWidth
`timescale 1ns/1ps

module regBank #(
  parameter int TimerWidth = 24
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         regWrite,
  input  logic [1:0]                   regAddr,
  input  logic [spiPkg::DataWidth-1:0] regWdata,
  input  logic [TimerWidth-1:0]        timerValue,
  output logic [spiPkg::DataWidth-1:0] regRdata,
  output logic                         ledManual,
  output logic                         blinkEnable,
  output logic                         restartBlink,
  output logic [spiPkg::DataWidth-1:0] blinkPeriod
);

  localparam int Dw = spiPkg::DataWidth;

  // only bits 1:0 of control drive anything
  // the rest is kept so software reads back what it wrote
  logic [Dw-1:0] ctrlReg;
  logic [Dw-1:0] periodReg;
  logic [Dw-1:0] scratchReg;
  // timer widened to a full register word
  logic [Dw-1:0] timerExt;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      ctrlReg <= '0;
      periodReg <= '0;
      scratchReg <= '0;
    end
    else if (regWrite)
    begin
      case (regAddr)
        spiPkg::AddrCtrl: ctrlReg <= regWdata;
        spiPkg::AddrPeriod: periodReg <= regWdata;
        spiPkg::AddrScratch: scratchReg <= regWdata;
        // timer writes fall through and are lost
        default: ;
      endcase
    end
  end

  // divider restarts on the same edge the new value lands
  assign restartBlink = regWrite &&
                        (regAddr == spiPkg::AddrCtrl || regAddr == spiPkg::AddrPeriod);

  always_comb
  begin
    timerExt = '0;
    timerExt[TimerWidth-1:0] = timerValue;
  end

  // read mux, combinational on the current address
  always_comb
  begin
    case (regAddr)
      spiPkg::AddrCtrl: regRdata = ctrlReg;
      spiPkg::AddrPeriod: regRdata = periodReg;
      spiPkg::AddrTimer: regRdata = timerExt;
      default: regRdata = scratchReg;
    endcase
  end

  assign ledManual = ctrlReg[spiPkg::CtrlLedBit];
  assign blinkEnable = ctrlReg[spiPkg::CtrlBlinkBit];
  assign blinkPeriod = periodReg;

endmodule

/* hdl/ledTimer.sv */
// cycle timer and led driver; led[1] toggles every blinkPeriod+1 cycles and wraps silently
`timescale 1ns/1ps

module ledTimer #(
  parameter int TimerWidth = 24
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         blinkEnable,
  input  logic                         ledManual,
  input  logic                         restartBlink,
  input  logic [spiPkg::DataWidth-1:0] blinkPeriod,
  output logic [TimerWidth-1:0]        timerValue,
  output logic [1:0]                   led
);

  // divider counts 0 up to blinkPeriod inclusive
  logic [spiPkg::DataWidth-1:0] divCnt;
  logic blinkBit;

  // free-running, wraps at 2**TimerWidth
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      timerValue <= '0;
    else
      timerValue <= timerValue + 1'b1;
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      divCnt <= '0;
      blinkBit <= 1'b0;
    end
    else if (restartBlink || !blinkEnable)
    begin
      // start over from a dark led
      divCnt <= '0;
      blinkBit <= 1'b0;
    end
    else if (divCnt == blinkPeriod)
    begin
      // P+1 cycles between toggles
      divCnt <= '0;
      blinkBit <= !blinkBit;
    end
    else
      divCnt <= divCnt + 1'b1;
  end

  // blink bit is already cleared whenever blinking is off
  assign led = {blinkBit, ledManual};

endmodule

/* hdl/spiPeriphTop.sv */
// SPI mode 0 peripheral top; sck half period must be at least 4 clk cycles, single slave only
`timescale 1ns/1ps

module spiPeriphTop #(
  parameter int SyncStages = 3,
  parameter int TimerWidth = 24
) (
  input  logic       clk,
  input  logic       rstN,
  input  logic       sck,
  input  logic       ssel,
  input  logic       mosi,
  output logic       miso,
  output logic [1:0] led
);

  // pin side strobes
  logic sckRise;
  logic sckFall;
  logic frameStart;
  logic frameEnd;
  logic selActive;
  logic mosiBit;
  // byte interface between shifter and sequencer
  logic byteDone;
  logic [7:0] rxByte;
  logic txLoad;
  logic [7:0] txByte;
  // register access
  logic regWrite;
  logic [1:0] regAddr;
  logic [spiPkg::DataWidth-1:0] regWdata;
  logic [spiPkg::DataWidth-1:0] regRdata;
  // led and timer controls
  logic ledManual;
  logic blinkEnable;
  logic restartBlink;
  logic [spiPkg::DataWidth-1:0] blinkPeriod;
  logic [TimerWidth-1:0] timerValue;

  spiEdgeSync #(.SyncStages(SyncStages)) uSync (
    .clk(clk), .rstN(rstN), .sck(sck), .ssel(ssel), .mosi(mosi),
    .sckRise(sckRise), .sckFall(sckFall), .frameStart(frameStart),
    .frameEnd(frameEnd), .selActive(selActive), .mosiBit(mosiBit)
  );

  spiShiftUnit uShift (
    .clk(clk), .rstN(rstN), .sckRise(sckRise), .sckFall(sckFall),
    .selActive(selActive), .mosiBit(mosiBit), .txLoad(txLoad), .txByte(txByte),
    .rxByte(rxByte), .byteDone(byteDone), .miso(miso)
  );

  spiFrameCtrl uCtrl (
    .clk(clk), .rstN(rstN), .frameStart(frameStart), .frameEnd(frameEnd),
    .byteDone(byteDone), .rxByte(rxByte), .regRdata(regRdata), .txLoad(txLoad),
    .regWrite(regWrite), .txByte(txByte), .regAddr(regAddr), .regWdata(regWdata)
  );

  regBank #(.TimerWidth(TimerWidth)) uRegs (
    .clk(clk), .rstN(rstN), .regWrite(regWrite), .regAddr(regAddr),
    .regWdata(regWdata), .timerValue(timerValue), .regRdata(regRdata),
    .ledManual(ledManual), .blinkEnable(blinkEnable),
    .restartBlink(restartBlink), .blinkPeriod(blinkPeriod)
  );

  ledTimer #(.TimerWidth(TimerWidth)) uLed (
    .clk(clk), .rstN(rstN), .blinkEnable(blinkEnable), .ledManual(ledManual),
    .restartBlink(restartBlink), .blinkPeriod(blinkPeriod),
    .timerValue(timerValue), .led(led)
  );

endmodule

/* tests/tbSpiPeriph.sv */
// directed SPI mode 0 master testbench; assumes default SyncStages and 8 clk cycles per sck period
`timescale 1ns/1ps

module tbSpiPeriph;

  // identity byte returned during the command byte
  localparam logic [7:0] IdExp = 8'h5A;
  // 1 + 8 + 32 bits of 8 cycles + 1 + 4 + 8 clk cycles per frame
  localparam int FrameCycles = 278;
  // 14 frames plus the led checks come to roughly 4000 cycles
  localparam int CycleLimit = 20000;

  logic clk = 1'b0;
  logic rstN = 1'b0;
  logic sck = 1'b0;
  logic ssel = 1'b1;
  logic mosi = 1'b0;
  logic miso;
  logic [1:0] led;

  // bytes sent and received in the last frame, command byte first
  logic [7:0] txBuf [0:3];
  logic [7:0] rxBuf [0:3];
  int cycleCnt = 0;
  int errCnt = 0;
  int testCnt = 0;
  int failCnt = 0;
  // scratch contents the DUT should hold
  logic [23:0] scratchVal = 24'h0;

  spiPeriphTop uut (
    .clk(clk), .rstN(rstN), .sck(sck), .ssel(ssel), .mosi(mosi),
    .miso(miso), .led(led)
  );

  always #5 clk = !clk;

  always @(posedge clk)
  begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= CycleLimit)
    begin
      $display("timeout after %0d cycles, a test did not finish", cycleCnt);
      $display("Test failures found");
      $finish;
    end
  end

  // one frame of nBytes bytes, sck half period of 4 clk cycles
  task automatic spiFrame(input int nBytes);
    @(posedge clk);
    ssel <= 1'b0;
    // identity byte needs a few cycles to reach miso
    repeat (8) @(posedge clk);
    for (int b = 0; b < nBytes; b++)
    begin
      for (int i = 7; i >= 0; i--)
      begin
        // mode 0 puts data out while sck is low
        @(posedge clk);
        sck <= 1'b0;
        mosi <= txBuf[b][i];
        repeat (3) @(posedge clk);
        // miso sampled just ahead of the rising sck edge
        @(negedge clk);
        rxBuf[b][i] = miso;
        @(posedge clk);
        sck <= 1'b1;
        repeat (3) @(posedge clk);
      end
    end
    @(posedge clk);
    sck <= 1'b0;
    repeat (4) @(posedge clk);
    ssel <= 1'b1;
    repeat (8) @(posedge clk);
  endtask

  task automatic loadFrame(input logic [7:0] cmd, input logic [23:0] data);
    txBuf[0] = cmd;
    txBuf[1] = data[23:16];
    txBuf[2] = data[15:8];
    txBuf[3] = data[7:0];
  endtask

  // bit 7 of the command selects a write
  task automatic writeReg(input logic [1:0] addr, input logic [23:0] data);
    loadFrame({6'b100000, addr}, data);
    spiFrame(4);
  endtask

  task automatic readReg(input logic [1:0] addr, output logic [23:0] data);
    loadFrame({6'b000000, addr}, 24'h0);
    spiFrame(4);
    data = {rxBuf[1], rxBuf[2], rxBuf[3]};
  endtask

  task automatic reportMismatch(input string name, input logic [23:0] expVal,
                                input logic [23:0] actVal);
    $display("[ERROR] %s: expected %h, got %h", name, expVal, actVal);
    errCnt++;
  endtask

  task automatic finishTest(input string name, input int errBefore);
    testCnt++;
    if (errCnt == errBefore)
      $display("test %s: ok", name);
    else
    begin
      failCnt++;
      $display("test %s: failed with %0d errors", name, errCnt - errBefore);
    end
  endtask

  task automatic testResetRead();
    int errBefore;
    logic [23:0] val;
    errBefore = errCnt;
    @(negedge clk);
    if (led !== 2'b00)
      reportMismatch("resetRead", 24'h0, {22'h0, led});
    readReg(2'd3, val);
    if (rxBuf[0] !== IdExp)
      reportMismatch("resetRead", {16'h0, IdExp}, {16'h0, rxBuf[0]});
    if (val !== 24'h0)
      reportMismatch("resetRead", 24'h0, val);
    finishTest("resetRead", errBefore);
  endtask

  task automatic testWriteRead();
    int errBefore;
    logic [31:0] rnd;
    logic [23:0] scratchNew;
    logic [23:0] periodNew;
    logic [23:0] val;
    errBefore = errCnt;
    rnd = $urandom();
    scratchNew = rnd[23:0];
    rnd = $urandom();
    periodNew = rnd[23:0];
    writeReg(2'd3, scratchNew);
    writeReg(2'd1, periodNew);
    readReg(2'd3, val);
    if (val !== scratchNew)
      reportMismatch("writeRead scratch", scratchNew, val);
    readReg(2'd1, val);
    if (val !== periodNew)
      reportMismatch("writeRead period", periodNew, val);
    scratchVal = scratchNew;
    finishTest("writeRead", errBefore);
  endtask

  task automatic testManualLed();
    int errBefore;
    errBefore = errCnt;
    // manual bit on, blink bit off
    writeReg(2'd0, 24'h000001);
    for (int n = 0; n < 40; n++)
    begin
      @(negedge clk);
      if (led !== 2'b01)
      begin
        reportMismatch("manualLed", 24'h1, {22'h0, led});
        break;
      end
    end
    finishTest("manualLed", errBefore);
  endtask

  task automatic testAbortWrite();
    int errBefore;
    logic [23:0] val;
    errBefore = errCnt;
    // select drops after the second data byte
    loadFrame(8'h83, ~scratchVal);
    spiFrame(3);
    readReg(2'd3, val);
    if (val !== scratchVal)
      reportMismatch("abortWrite", scratchVal, val);
    finishTest("abortWrite", errBefore);
  endtask

  task automatic testTimer();
    int errBefore;
    logic [23:0] t1;
    logic [23:0] t2;
    logic [23:0] t3;
    errBefore = errCnt;
    readReg(2'd2, t1);
    readReg(2'd2, t2);
    if (t2 <= t1)
    begin
      $display("timer did not advance between reads, first %h, second %h", t1, t2);
      errCnt++;
    end
    // back to back frames snapshot the timer exactly one frame apart
    if (t2 - t1 !== 24'(FrameCycles))
      reportMismatch("timer step", 24'(FrameCycles), t2 - t1);
    writeReg(2'd2, 24'h0);
    readReg(2'd2, t3);
    if (t3 <= t2)
    begin
      $display("timer went back after a write to its address, %h then %h", t2, t3);
      errCnt++;
    end
    finishTest("timer", errBefore);
  endtask

  task automatic testBlink();
    int errBefore;
    int lastEdge;
    int gap;
    logic prevLed;
    errBefore = errCnt;
    writeReg(2'd1, 24'd5);
    writeReg(2'd0, 24'h000002);
    @(negedge clk);
    prevLed = led[1];
    lastEdge = -1;
    for (int n = 0; n < 6; n++)
    begin
      gap = 0;
      while (led[1] === prevLed && gap < 20)
      begin
        @(negedge clk);
        gap++;
      end
      if (led[1] === prevLed)
      begin
        $display("led[1] stopped toggling while blinking was enabled");
        errCnt++;
        break;
      end
      prevLed = led[1];
      // P+1 cycles between edges
      if (lastEdge >= 0 && cycleCnt - lastEdge != 6)
        reportMismatch("blink gap", 24'd6, 24'(cycleCnt - lastEdge));
      if (led[0] !== 1'b0)
        reportMismatch("blink manual", 24'h0, {23'h0, led[0]});
      lastEdge = cycleCnt;
    end
    finishTest("blink", errBefore);
  endtask

  initial
  begin
    void'($urandom(32'h8aee4706));
    repeat (4) @(posedge clk);
    rstN <= 1'b1;
    testResetRead();
    testWriteRead();
    testManualLed();
    testAbortWrite();
    testTimer();
    testBlink();
    $display("%0d tests run, %0d failed, %0d errors", testCnt, failCnt, errCnt);
    if (errCnt == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* all.f */
hdl/spiPkg.sv
hdl/spiEdgeSync.sv
hdl/spiShiftUnit.sv
hdl/spiFrameCtrl.sv
hdl/regBank.sv
hdl/ledTimer.sv
hdl/spiPeriphTop.sv
tests/tbSpiPeriph.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and decide the result from the simulation output
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module tbSpiPeriph -o simv
out=$(./obj_dir/simv)
echo "$out"
if echo "$out" | grep -q "All tests passed!"; then
  exit 0
fi
exit 1
